// File: boot_rom.sv
// boot ROM slave
`timescale 1ns/1ns

module boot_rom
  import bus_pkg::*;
(
  input  logic     clock,
  input  logic     rst_n,
  mem_bus_if.slave bus
);

  word_t mem [ROM_WORDS];
  logic  ack_q;

  initial begin
    $readmemh("rom.hex", mem);
  end

  // writes have no effect but still complete
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= bus.rd_en | bus.wr_en;
    end
  end

  assign bus.ack   = ack_q;
  assign bus.dat_r = mem[bus.adr[ROM_IDX_W+1:2]];  // aliases within the region

endmodule

// File: bus_pkg.sv
// system bus definitions
package bus_pkg;

  // bus widths
  localparam int WORD_W         = 32;
  localparam int BYTES_PER_WORD = WORD_W / 8;

  typedef logic [WORD_W-1:0]         word_t;     // one data word
  typedef logic [31:0]               addr_t;     // byte address
  typedef logic [BYTES_PER_WORD-1:0] byte_en_t;  // one enable per byte lane

  // address map, region is the top byte of the address
  localparam int REGION_LSB = 24;
  typedef logic [7:0] region_t;

  localparam region_t ROM_REGION       = 8'h00;  // 16 MiB window
  localparam region_t RAM_FIRST_REGION = 8'h01;
  localparam region_t RAM_LAST_REGION  = 8'h04;  // 64 MiB window in total

  // remapped RAM offset is zero based, 4 regions of 24 bits
  localparam int RAM_OFFSET_W = 26;

  // timer registers at the top of the address space
  localparam addr_t MSIP_ADDR     = 32'hFFFF_FFC0;
  localparam addr_t MTIME_ADDR    = 32'hFFFF_FFE0;  // 8 byte aligned
  localparam addr_t MTIMECMP_ADDR = 32'hFFFF_FFF0;  // 8 byte aligned

  // modelled storage depths
  localparam int RAM_WORDS = 256;
  localparam int RAM_IDX_W = $clog2(RAM_WORDS);
  localparam int ROM_WORDS = 16;
  localparam int ROM_IDX_W = $clog2(ROM_WORDS);

  typedef logic [RAM_IDX_W-1:0] ram_idx_t;  // RAM word index

  // cycles the RAM waits before it acknowledges
  localparam int RAM_WAIT_STATES = 2;

endpackage

// File: clint_pkg.sv
// machine timer definitions
package clint_pkg;

  // bits 1:0 name the register, bit 2 picks the high word
  typedef logic [2:0] csr_sel_t;
  typedef logic [63:0] mtime_t;

  localparam logic [1:0] SEL_MSIP     = 2'b00;
  localparam logic [1:0] SEL_MTIME    = 2'b10;
  localparam logic [1:0] SEL_MTIMECMP = 2'b11;
  localparam int         SEL_HI_BIT   = 2;

  // reset values, an all ones compare keeps timer_irq low
  localparam mtime_t MTIME_RESET    = '0;
  localparam mtime_t MTIMECMP_RESET = '1;
  localparam logic   MSIP_RESET     = 1'b0;

endpackage

// File: machine_timer.sv
// machine timer and software interrupt
`timescale 1ns/1ns

module machine_timer
  import bus_pkg::*;
  import clint_pkg::*;
(
  input  logic     clock,
  input  logic     rst_n,
  mem_bus_if.slave bus,
  output logic     timer_irq,
  output logic     software_irq
);

  mtime_t   mtime;
  mtime_t   mtimecmp;
  logic     msip;
  logic     ack_q;
  logic     wr_stb;
  csr_sel_t sel;

  assign sel    = bus.adr[$bits(csr_sel_t)-1:0];
  assign wr_stb = bus.wr_en & ~ack_q;  // one write per request, on the ack edge

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= bus.rd_en | bus.wr_en;
    end
  end

  // free running, a bus write replaces one half
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      mtime <= MTIME_RESET;
    end else if (wr_stb && sel[1:0] == SEL_MTIME) begin
      if (sel[SEL_HI_BIT]) mtime[63:32] <= bus.dat_w;
      else                 mtime[31:0]  <= bus.dat_w;
    end else begin
      mtime <= mtime + 1'b1;
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      mtimecmp <= MTIMECMP_RESET;
      msip     <= MSIP_RESET;
    end else if (wr_stb) begin
      if (sel[1:0] == SEL_MTIMECMP) begin
        if (sel[SEL_HI_BIT]) mtimecmp[63:32] <= bus.dat_w;
        else                 mtimecmp[31:0]  <= bus.dat_w;
      end
      if (sel[1:0] == SEL_MSIP) msip <= bus.dat_w[0];
    end
  end

  always_comb begin
    case (sel[1:0])
      SEL_MSIP:     bus.dat_r = word_t'(msip);
      SEL_MTIME:    bus.dat_r = sel[SEL_HI_BIT] ? mtime[63:32] : mtime[31:0];
      SEL_MTIMECMP: bus.dat_r = sel[SEL_HI_BIT] ? mtimecmp[63:32] : mtimecmp[31:0];
      default:      bus.dat_r = '0;
    endcase
  end

  assign bus.ack      = ack_q;
  assign timer_irq    = (mtime >= mtimecmp);
  assign software_irq = msip;

endmodule

// File: mem_bus_if.sv
// decoder to slave bus
`timescale 1ns/1ns

interface mem_bus_if
  import bus_pkg::*;
();

  logic     rd_en;    // read strobe, held until ack
  logic     wr_en;    // write strobe, held until ack
  addr_t    adr;
  word_t    dat_w;
  byte_en_t byte_en;
  word_t    dat_r;
  logic     ack;      // high while the request is held

  modport master (
    output rd_en, wr_en, adr, dat_w, byte_en,
    input  dat_r, ack
  );

  modport slave (
    input  rd_en, wr_en, adr, dat_w, byte_en,
    output dat_r, ack
  );

endinterface

// File: memory_controller.sv
// memory bus address decoder
`timescale 1ns/1ns

module memory_controller
  import bus_pkg::*;
  import clint_pkg::*;
(
  input  logic      cyc,
  input  logic      stb,
  input  logic      we,
  input  byte_en_t  byte_en,
  input  addr_t     adr,
  input  word_t     dat_w,
  output word_t     dat_r,
  output logic      ack,
  mem_bus_if.master rom_bus,
  mem_bus_if.master ram_bus,
  mem_bus_if.master timer_bus
);

  region_t  region;
  region_t  ram_region_off;
  logic     mem_rd_en;
  logic     mem_wr_en;
  logic     rom_cs;
  logic     ram_cs;
  logic     msip_cs;
  logic     mtime_cs;
  logic     mtimecmp_cs;
  logic     timer_cs;
  csr_sel_t timer_sel;

  // qualified strobes from the cpu side
  assign mem_rd_en = cyc & stb & ~we;
  assign mem_wr_en = cyc & stb & we;

  assign region = adr[31:REGION_LSB];

  assign rom_cs = (region == ROM_REGION);
  assign ram_cs = (region >= RAM_FIRST_REGION) && (region <= RAM_LAST_REGION);

  // 64-bit timer registers answer at both word addresses
  assign msip_cs     = (adr == MSIP_ADDR);
  assign mtime_cs    = (adr[31:3] == MTIME_ADDR[31:3]) && (adr[1:0] == MTIME_ADDR[1:0]);
  assign mtimecmp_cs = (adr[31:3] == MTIMECMP_ADDR[31:3]) &&
                       (adr[1:0] == MTIMECMP_ADDR[1:0]);
  assign timer_cs    = msip_cs | mtime_cs | mtimecmp_cs;

  // region 1 maps to offset 0
  assign ram_region_off = region - RAM_FIRST_REGION;

  always_comb begin
    timer_sel[SEL_HI_BIT] = adr[2];  // high or low word
    if (mtime_cs) begin
      timer_sel[1:0] = SEL_MTIME;
    end else if (mtimecmp_cs) begin
      timer_sel[1:0] = SEL_MTIMECMP;
    end else begin
      timer_sel[1:0] = SEL_MSIP;
    end
  end

  // boot rom, address masked to the region
  assign rom_bus.rd_en   = rom_cs & mem_rd_en;
  assign rom_bus.wr_en   = rom_cs & mem_wr_en;
  assign rom_bus.adr     = {{(32-REGION_LSB){1'b0}}, adr[REGION_LSB-1:0]};
  assign rom_bus.dat_w   = dat_w;
  assign rom_bus.byte_en = rom_cs ? byte_en : '0;

  // ram, zero based offset
  assign ram_bus.rd_en   = ram_cs & mem_rd_en;
  assign ram_bus.wr_en   = ram_cs & mem_wr_en;
  assign ram_bus.adr     = {{(32-RAM_OFFSET_W){1'b0}},
                            ram_region_off[RAM_OFFSET_W-REGION_LSB-1:0],
                            adr[REGION_LSB-1:0]};
  assign ram_bus.dat_w   = dat_w;
  assign ram_bus.byte_en = ram_cs ? byte_en : '0;

  // timer gets the register index as its address
  assign timer_bus.rd_en   = timer_cs & mem_rd_en;
  assign timer_bus.wr_en   = timer_cs & mem_wr_en;
  assign timer_bus.adr     = addr_t'(timer_sel);
  assign timer_bus.dat_w   = dat_w;
  assign timer_bus.byte_en = timer_cs ? byte_en : '0;

  // return path, unmapped gives no ack and zero data
  assign ack = rom_cs   ? rom_bus.ack
             : ram_cs   ? ram_bus.ack
             : timer_cs ? timer_bus.ack
             : 1'b0;

  assign dat_r = rom_cs   ? rom_bus.dat_r
               : ram_cs   ? ram_bus.dat_r
               : timer_cs ? timer_bus.dat_r
               : '0;

endmodule

// File: ram_access_fsm.sv
// RAM wait-state controller
`timescale 1ns/1ns

module ram_access_fsm
  import bus_pkg::*;
(
  input  logic     clock,
  input  logic     rst_n,
  mem_bus_if.slave bus
);

  localparam int CNT_W = $clog2(RAM_WAIT_STATES + 1);

  typedef enum logic [1:0] {
    idle,
    wait_st,
    ack_st
  } ram_state_t;

  ram_state_t       state;
  logic [CNT_W-1:0] wait_cnt;
  logic             req;
  logic             last_wait;
  logic             arr_wr_en;

  assign req       = bus.rd_en | bus.wr_en;
  assign last_wait = (wait_cnt == CNT_W'(RAM_WAIT_STATES - 1));

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state    <= idle;
      wait_cnt <= '0;
    end else begin
      case (state)
        idle: begin
          if (req) begin
            state    <= wait_st;
            wait_cnt <= '0;
          end
        end
        wait_st: begin
          if (!req) begin
            state <= idle;  // request withdrawn early
          end else if (last_wait) begin
            state <= ack_st;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        ack_st: begin
          if (!req) state <= idle;  // ack drops on the next edge
        end
        default: state <= idle;
      endcase
    end
  end

  // single write pulse on the edge that raises ack
  assign arr_wr_en = (state == wait_st) & last_wait & bus.wr_en;
  assign bus.ack   = (state == ack_st);

  ram_array i_ram_array (
    .clock   (clock),
    .wr_en   (arr_wr_en),
    .byte_en (bus.byte_en),
    .adr     (bus.adr[RAM_IDX_W+1:2]),  // word index
    .dat_w   (bus.dat_w),
    .dat_r   (bus.dat_r)
  );

endmodule

// File: ram_array.sv
// byte-writable RAM storage
`timescale 1ns/1ns

module ram_array
  import bus_pkg::*;
(
  input  logic     clock,
  input  logic     wr_en,
  input  byte_en_t byte_en,
  input  ram_idx_t adr,
  input  word_t    dat_w,
  output word_t    dat_r
);

  word_t mem [RAM_WORDS];

  always_ff @(posedge clock) begin
    if (wr_en) begin
      for (int b = 0; b < BYTES_PER_WORD; b++) begin
        if (byte_en[b]) mem[adr][8*b +: 8] <= dat_w[8*b +: 8];  // enabled lanes only
      end
    end
  end

  assign dat_r = mem[adr];  // asynchronous read

endmodule

// File: rom.hex
// boot rom image, one 32-bit word per line in hex, word index 0 to 15
00000297
02028293
30529073
010002b7
00028113
00000513
00000593
0040006f
00100073
0000006f
00000013
fe010113
00112e23
00812c23
02010413
00008067

// File: sim.f
bus_pkg.sv
clint_pkg.sv
mem_bus_if.sv
ram_array.sv
ram_access_fsm.sv
boot_rom.sv
machine_timer.sv
memory_controller.sv
soc_bus_top.sv
tb_soc_bus.sv

// File: soc_bus_top.sv
// SoC memory bus top level
`timescale 1ns/1ns

module soc_bus_top
  import bus_pkg::*;
(
  input  logic     clock,
  input  logic     rst_n,
  input  logic     cyc,
  input  logic     stb,
  input  logic     we,
  input  byte_en_t byte_en,
  input  addr_t    adr,
  input  word_t    dat_w,
  output word_t    dat_r,
  output logic     ack,
  output logic     timer_irq,
  output logic     software_irq
);

  // one bus per slave
  mem_bus_if rom_bus ();
  mem_bus_if ram_bus ();
  mem_bus_if timer_bus ();

  memory_controller i_memory_controller (
    .cyc       (cyc),
    .stb       (stb),
    .we        (we),
    .byte_en   (byte_en),
    .adr       (adr),
    .dat_w     (dat_w),
    .dat_r     (dat_r),
    .ack       (ack),
    .rom_bus   (rom_bus.master),
    .ram_bus   (ram_bus.master),
    .timer_bus (timer_bus.master)
  );

  boot_rom i_boot_rom (
    .clock (clock),
    .rst_n (rst_n),
    .bus   (rom_bus.slave)
  );

  ram_access_fsm i_ram_access_fsm (
    .clock (clock),
    .rst_n (rst_n),
    .bus   (ram_bus.slave)
  );

  machine_timer i_machine_timer (
    .clock        (clock),
    .rst_n        (rst_n),
    .bus          (timer_bus.slave),
    .timer_irq    (timer_irq),
    .software_irq (software_irq)
  );

endmodule

// File: tb_soc_bus.sv
// SoC memory bus testbench
`timescale 1ns/1ns

module tb_soc_bus
  import bus_pkg::*;
();

  localparam int ACK_TIMEOUT = 50;
  localparam int IRQ_TIMEOUT = 150;
  localparam int RAM_CHECKS  = 200;

  logic     clock;
  logic     rst_n;
  logic     cyc;
  logic     stb;
  logic     we;
  byte_en_t byte_en;
  addr_t    adr;
  word_t    dat_w;
  word_t    dat_r;
  logic     ack;
  logic     timer_irq;
  logic     software_irq;

  word_t shadow [RAM_WORDS];   // reference RAM contents
  word_t rom_ref [ROM_WORDS];
  int    seed = 63314;
  int    cycle_count = 0;
  int    last_latency;         // cycles from request sample to ack
  logic  irq_at_ack;           // timer_irq seen on the ack edge

  soc_bus_top i_dut (
    .clock        (clock),
    .rst_n        (rst_n),
    .cyc          (cyc),
    .stb          (stb),
    .we           (we),
    .byte_en      (byte_en),
    .adr          (adr),
    .dat_w        (dat_w),
    .dat_r        (dat_r),
    .ack          (ack),
    .timer_irq    (timer_irq),
    .software_irq (software_irq)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  always @(posedge clock) cycle_count <= cycle_count + 1;

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("MISMATCH at %0t: %s expected %h, got %h",
                              $time, name, expected, actual));
    end
  endtask

  function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                        input byte_en_t be);
    word_t merged;
    merged = old_w;
    for (int b = 0; b < BYTES_PER_WORD; b++) begin
      if (be[b]) merged[8*b +: 8] = new_w[8*b +: 8];
    end
    return merged;
  endfunction

  // region 1 starts at offset 0 and storage wraps every RAM_WORDS words
  function automatic int ram_index(input addr_t a);
    logic [31:0] offset;
    offset = {6'b0, 2'(a[31:24] - RAM_FIRST_REGION), a[23:0]};
    return int'((offset >> 2) % RAM_WORDS);
  endfunction

  function automatic word_t expected_read(input addr_t a);
    return shadow[ram_index(a)];
  endfunction

  function automatic word_t fill_word(input ram_idx_t i);
    return {~i, i, i ^ 8'h5a, i + 8'h3c};
  endfunction

  // random region and upper offset bits around a fixed word index
  function automatic addr_t random_ram_addr(input ram_idx_t idx);
    logic [31:0] r;
    r = $random(seed);
    return {RAM_FIRST_REGION + region_t'(r[1:0]), r[23:10], idx, 2'b00};
  endfunction

  task automatic bus_access(input logic write, input addr_t a, input word_t wdata,
                            input byte_en_t be, output word_t rdata);
    int cycles;
    @(posedge clock);
    cyc     <= 1'b1;
    stb     <= 1'b1;
    we      <= write;
    adr     <= a;
    dat_w   <= wdata;
    byte_en <= be;
    cycles = 0;
    @(posedge clock);  // first edge that samples the request
    do begin
      @(posedge clock);
      cycles++;
      if (cycles > ACK_TIMEOUT) begin
        stop_on_error($sformatf("no ack from address %h within %0d cycles", a, ACK_TIMEOUT));
      end
    end while (!ack);
    rdata        = dat_r;
    irq_at_ack   = timer_irq;
    last_latency = cycles;
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
    @(posedge clock);
    check_value("ack held", 1, ack);  // falls one cycle after stb drops
    @(posedge clock);
    check_value("ack released", 0, ack);
  endtask

  task automatic bus_write(input addr_t a, input word_t d, input byte_en_t be);
    word_t unused;
    bus_access(1'b1, a, d, be, unused);
  endtask

  task automatic bus_read(input addr_t a, output word_t d);
    bus_access(1'b0, a, '0, '1, d);
  endtask

  task automatic verify_mtime_counts();
    word_t t1;
    word_t t2;
    bus_read(MTIME_ADDR, t1);
    check_value("timer ack latency", 1, last_latency);
    bus_read(MTIME_ADDR, t2);
    if (t2 <= t1) begin
      stop_on_error($sformatf("mtime low word did not increase, read %h then %h", t1, t2));
    end
  endtask

  task automatic exercise_interrupts();
    word_t t;
    word_t cmp;
    int    start;
    bus_write(MSIP_ADDR, 32'h1, '1);
    check_value("timer write ack latency", 1, last_latency);
    check_value("software_irq", 1, software_irq);
    bus_write(MSIP_ADDR, 32'h0, '1);
    check_value("software_irq", 0, software_irq);
    bus_read(MTIME_ADDR, t);
    cmp = t + 100;
    bus_write(MTIMECMP_ADDR, cmp, '1);       // low word first while the high word is all ones
    bus_write(MTIMECMP_ADDR + 4, 32'h0, '1);
    start = cycle_count;
    do begin
      bus_read(MTIME_ADDR, t);
      check_value("timer_irq", word_t'(t >= cmp), word_t'(irq_at_ack));
      if (!irq_at_ack && cycle_count - start > IRQ_TIMEOUT) begin
        stop_on_error("timer_irq did not rise within 150 cycles of the mtimecmp write");
      end
    end while (!irq_at_ack);
  endtask

  task automatic read_all_rom();
    word_t d;
    for (int i = 0; i < ROM_WORDS; i++) begin
      bus_read(addr_t'(i * 4), d);
      check_value("rom dat_r", rom_ref[i], d);
      check_value("rom ack latency", 1, last_latency);
      bus_read(addr_t'(32'h0012_3440 + i * 4), d);  // alias above the 16 words
      check_value("rom alias dat_r", rom_ref[i], d);
    end
  endtask

  task automatic random_ram_traffic();
    logic [31:0] r;
    addr_t       a;
    word_t       d;
    byte_en_t    be;
    for (int i = 0; i < RAM_WORDS; i++) begin
      a = {RAM_FIRST_REGION + region_t'(i % 4), 14'h0, ram_idx_t'(i), 2'b00};
      bus_write(a, fill_word(ram_idx_t'(i)), '1);
      shadow[ram_index(a)] = fill_word(ram_idx_t'(i));
    end
    for (int n = 0; n < RAM_CHECKS; n++) begin
      r  = $random(seed);
      d  = $random(seed);
      be = r[2] ? r[7:4] : 4'hf;
      a  = random_ram_addr(r[15:8]);
      bus_write(a, d, be);
      check_value("ram write ack latency", RAM_WAIT_STATES + 1, last_latency);
      shadow[ram_index(a)] = merge_bytes(shadow[ram_index(a)], d, be);
      a = random_ram_addr(r[15:8]);  // same word through another region
      bus_read(a, d);
      check_value("ram dat_r", expected_read(a), d);
      check_value("ram read ack latency", RAM_WAIT_STATES + 1, last_latency);
      a = random_ram_addr(r[23:16]);
      bus_read(a, d);
      check_value("ram dat_r", expected_read(a), d);
    end
  endtask

  task automatic probe_unmapped();
    int    cycles;
    word_t d;
    @(posedge clock);
    cyc     <= 1'b1;
    stb     <= 1'b1;
    we      <= 1'b0;
    adr     <= 32'h0900_0000;  // region 9
    byte_en <= '1;
    @(posedge clock);
    cycles = 0;
    while (cycles < 20) begin
      @(posedge clock);
      cycles++;
      check_value("ack", 0, ack);
      check_value("dat_r", 0, dat_r);
    end
    cyc <= 1'b0;
    stb <= 1'b0;
    bus_read(32'h0000_0008, d);
    check_value("rom dat_r after unmapped access", rom_ref[2], d);
  endtask

  initial begin
    rst_n   = 1'b0;
    cyc     = 1'b0;
    stb     = 1'b0;
    we      = 1'b0;
    byte_en = '0;
    adr     = '0;
    dat_w   = '0;
    $readmemh("rom.hex", rom_ref);
    repeat (4) @(posedge clock);
    rst_n <= 1'b1;
    @(posedge clock);
    check_value("timer_irq", 0, timer_irq);
    check_value("software_irq", 0, software_irq);
    verify_mtime_counts();
    exercise_interrupts();
    read_all_rom();
    random_ram_traffic();
    probe_unmapped();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule
